// File: hw/updi_macros.svh
// timing constants are in clk cycles, so they must be scaled to the clock the sequencer runs on
`ifndef UPDI_MACROS_SVH
`define UPDI_MACROS_SVH

// every UPDI frame opens with this byte
`define UPDI_SYNCH 8'h55

// wait after the reset signature and between SYS_STATUS polls
`define UPDI_RESET_DELAY_CLKS 100

// idle cycles allowed per awaited response byte
`define UPDI_RX_TIMEOUT_CLKS 200

// "NVMProg " as one word, sent least significant byte first
`define UPDI_KEY_NVMPROG 64'h4E564D50726F6720

`endif

// File: hw/updi_proto_pkg.sv
// only the opcode fields used by LDCS/STCS/KEY/REPEAT and ST/LD pointer access are modelled
package updi_proto_pkg;

	// opcode class, held in bits 7:5 of the opcode byte
	typedef enum logic [2:0] {
		UPDI_LDS    = 3'd0,
		UPDI_LD     = 3'd1,
		UPDI_STS    = 3'd2,
		UPDI_ST     = 3'd3,
		UPDI_LDCS   = 3'd4,
		UPDI_REPEAT = 3'd5,
		UPDI_STCS   = 3'd6,
		UPDI_KEY    = 3'd7
	} updi_opc_e;

	// control/status access and pointer access decode the same byte differently
	typedef union packed {
		struct packed {
			updi_opc_e  opc;
			logic       rsvd;
			logic [3:0] cs_addr;
		} cs;
		struct packed {
			updi_opc_e  opc;
			logic       rsvd;
			logic [1:0] ptr;
			logic [1:0] size;
		} ptr;
	} updi_opcode_u;

	localparam int UPDI_MAX_OPERANDS = 8;

	// pointer modes and access sizes for LD/ST
	localparam logic [1:0] UPDI_PTR_INC = 2'b01;
	localparam logic [1:0] UPDI_PTR_REG = 2'b10;
	localparam logic [1:0] UPDI_SIZE_BYTE = 2'b00;
	localparam logic [1:0] UPDI_SIZE_WORD = 2'b01;

	function automatic updi_opcode_u cs_opcode(updi_opc_e opc, logic [3:0] addr);
		updi_opcode_u op;
		op.cs.opc = opc;
		op.cs.rsvd = 1'b0;
		op.cs.cs_addr = addr;
		return op;
	endfunction

	function automatic updi_opcode_u ptr_opcode(updi_opc_e opc, logic [1:0] ptr,
			logic [1:0] size);
		updi_opcode_u op;
		op.ptr.opc = opc;
		op.ptr.rsvd = 1'b0;
		op.ptr.ptr = ptr;
		op.ptr.size = size;
		return op;
	endfunction

endpackage

// File: hw/updi_asi_pkg.sv
// register map follows the tinyAVR/megaAVR 0-series UPDI; other families may differ
package updi_asi_pkg;

	// control/status space
	localparam logic [3:0] ASI_STATUSA    = 4'h0;
	localparam logic [3:0] ASI_KEY_STATUS = 4'h7;
	localparam logic [3:0] ASI_RESET_REQ  = 4'h8;
	localparam logic [3:0] ASI_SYS_STATUS = 4'hB;

	localparam int KEY_NVMPROG_BIT = 4;
	localparam int SYS_NVMPROG_BIT = 3;

	localparam logic [7:0] RESET_SIGNATURE = 8'h59;
	localparam logic [15:0] SIGROW_BASE = 16'h1100;
	localparam int DEVICE_ID_BYTES = 3;

	// each step issues in *_REQ and waits for frame and reply in *_WAIT
	typedef enum logic [4:0] {
		SEQ_IDLE,
		SEQ_DB_START,
		SEQ_DB_WAIT,
		SEQ_STATUSA_REQ,
		SEQ_STATUSA_WAIT,
		SEQ_KEY_REQ,
		SEQ_KEY_WAIT,
		SEQ_KEYSTAT_REQ,
		SEQ_KEYSTAT_WAIT,
		SEQ_RST_SET_REQ,
		SEQ_RST_SET_WAIT,
		SEQ_RST_DELAY,
		SEQ_RST_CLR_REQ,
		SEQ_RST_CLR_WAIT,
		SEQ_SYS_REQ,
		SEQ_SYS_WAIT,
		SEQ_SYS_DELAY,
		SEQ_PTR_REQ,
		SEQ_PTR_WAIT,
		SEQ_RPT_REQ,
		SEQ_RPT_WAIT,
		SEQ_LD_REQ,
		SEQ_LD_WAIT
	} seq_state_e;

endpackage

// File: hw/updi_sequencer.sv
// a failed check or rx_timeout pulses error and returns to idle; there is no automatic retry
`timescale 1ns/1ps
`include "updi_macros.svh"

module updi_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic busy,
	output logic done,
	output logic error,
	output logic [23:0] device_id,
	output logic double_break_start,
	input  logic double_break_done,
	output logic cmd_valid,
	output updi_proto_pkg::updi_opcode_u cmd_opcode,
	output logic [63:0] cmd_operands,
	output logic [3:0] cmd_operand_count,
	input  logic builder_ready,
	input  logic frame_sent,
	output logic rx_expect,
	output logic [1:0] rx_count,
	input  logic resp_valid,
	input  logic [7:0] resp_byte,
	input  logic resp_done,
	input  logic rx_timeout
);
	import updi_proto_pkg::*;
	import updi_asi_pkg::*;

	localparam int DELAY_W = $clog2(`UPDI_RESET_DELAY_CLKS + 1);

	seq_state_e state, wait_state;
	logic tx_pend, rx_pend, step_done;
	logic [DELAY_W-1:0] delay_cnt;
	logic [7:0] last_resp, chk_byte;
	logic is_req, nxt_rx;
	updi_opcode_u nxt_opcode;
	logic [63:0] nxt_operands;
	logic [3:0] nxt_count;
	logic [1:0] nxt_rx_count;

	assign busy = (state != SEQ_IDLE);
	assign double_break_start = (state == SEQ_DB_START);

	// a step ends once its frame is out and any reply has arrived
	assign step_done = !(tx_pend && !frame_sent) && !(rx_pend && !resp_done);
	assign chk_byte = resp_valid ? resp_byte : last_resp;

	// command issued from each request state
	always_comb begin
		is_req = 1'b1;
		nxt_opcode = cs_opcode(UPDI_LDCS, ASI_STATUSA);
		nxt_operands = '0;
		nxt_count = 4'd0;
		nxt_rx = 1'b0;
		nxt_rx_count = 2'd0;
		wait_state = SEQ_IDLE;
		case (state)
			SEQ_STATUSA_REQ: begin
				nxt_rx = 1'b1;
				nxt_rx_count = 2'd1;
				wait_state = SEQ_STATUSA_WAIT;
			end
			SEQ_KEY_REQ: begin
				nxt_opcode = cs_opcode(UPDI_KEY, 4'h0);
				nxt_operands = `UPDI_KEY_NVMPROG;
				nxt_count = 4'd8;
				wait_state = SEQ_KEY_WAIT;
			end
			SEQ_KEYSTAT_REQ: begin
				nxt_opcode = cs_opcode(UPDI_LDCS, ASI_KEY_STATUS);
				nxt_rx = 1'b1;
				nxt_rx_count = 2'd1;
				wait_state = SEQ_KEYSTAT_WAIT;
			end
			SEQ_RST_SET_REQ, SEQ_RST_CLR_REQ: begin
				nxt_opcode = cs_opcode(UPDI_STCS, ASI_RESET_REQ);
				nxt_operands[7:0] = (state == SEQ_RST_SET_REQ) ? RESET_SIGNATURE : 8'h00;
				nxt_count = 4'd1;
				wait_state = (state == SEQ_RST_SET_REQ) ? SEQ_RST_SET_WAIT : SEQ_RST_CLR_WAIT;
			end
			SEQ_SYS_REQ: begin
				nxt_opcode = cs_opcode(UPDI_LDCS, ASI_SYS_STATUS);
				nxt_rx = 1'b1;
				nxt_rx_count = 2'd1;
				wait_state = SEQ_SYS_WAIT;
			end
			SEQ_PTR_REQ: begin
				// pointer load is a word, low byte first
				nxt_opcode = ptr_opcode(UPDI_ST, UPDI_PTR_REG, UPDI_SIZE_WORD);
				nxt_operands[15:0] = SIGROW_BASE;
				nxt_count = 4'd2;
				wait_state = SEQ_PTR_WAIT;
			end
			SEQ_RPT_REQ: begin
				nxt_opcode = cs_opcode(UPDI_REPEAT, 4'h0);
				nxt_operands[7:0] = 8'(DEVICE_ID_BYTES - 1);
				nxt_count = 4'd1;
				wait_state = SEQ_RPT_WAIT;
			end
			SEQ_LD_REQ: begin
				nxt_opcode = ptr_opcode(UPDI_LD, UPDI_PTR_INC, UPDI_SIZE_BYTE);
				nxt_rx = 1'b1;
				nxt_rx_count = 2'(DEVICE_ID_BYTES);
				wait_state = SEQ_LD_WAIT;
			end
			default: is_req = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (is_req && builder_ready) begin
			cmd_opcode <= nxt_opcode;
			cmd_operands <= nxt_operands;
			cmd_operand_count <= nxt_count;
			rx_count <= nxt_rx_count;
		end
		if (resp_valid) begin
			last_resp <= resp_byte;
		end
	end

	always_ff @(posedge clk) begin
		cmd_valid <= 1'b0;
		rx_expect <= 1'b0;
		done <= 1'b0;
		error <= 1'b0;
		if (rst) begin
			state <= SEQ_IDLE;
			tx_pend <= 1'b0;
			rx_pend <= 1'b0;
			delay_cnt <= '0;
			device_id <= '0;
		end else begin
			if (frame_sent) begin
				tx_pend <= 1'b0;
			end
			if (resp_done) begin
				rx_pend <= 1'b0;
			end
			if (delay_cnt != '0) begin
				delay_cnt <= delay_cnt - 1'b1;
			end
			if (rx_timeout) begin
				error <= 1'b1;
				state <= SEQ_IDLE;
			end else if (is_req) begin
				if (builder_ready) begin
					cmd_valid <= 1'b1;
					rx_expect <= nxt_rx;
					tx_pend <= 1'b1;
					rx_pend <= nxt_rx;
					state <= wait_state;
				end
			end else begin
				case (state)
					SEQ_IDLE: begin
						if (start) begin
							device_id <= '0;
							state <= SEQ_DB_START;
						end
					end
					SEQ_DB_START: state <= SEQ_DB_WAIT;
					SEQ_DB_WAIT: begin
						if (double_break_done) begin
							state <= SEQ_STATUSA_REQ;
						end
					end
					SEQ_STATUSA_WAIT: begin
						// a dead link reads back as zero
						if (step_done) begin
							state <= (chk_byte != 8'h00) ? SEQ_KEY_REQ : SEQ_IDLE;
							error <= (chk_byte == 8'h00);
						end
					end
					SEQ_KEY_WAIT: begin
						if (step_done) begin
							state <= SEQ_KEYSTAT_REQ;
						end
					end
					SEQ_KEYSTAT_WAIT: begin
						if (step_done) begin
							state <= chk_byte[KEY_NVMPROG_BIT] ? SEQ_RST_SET_REQ : SEQ_IDLE;
							error <= !chk_byte[KEY_NVMPROG_BIT];
						end
					end
					SEQ_RST_SET_WAIT: begin
						if (step_done) begin
							delay_cnt <= DELAY_W'(`UPDI_RESET_DELAY_CLKS - 1);
							state <= SEQ_RST_DELAY;
						end
					end
					SEQ_RST_DELAY: begin
						if (delay_cnt == '0) begin
							state <= SEQ_RST_CLR_REQ;
						end
					end
					SEQ_RST_CLR_WAIT: begin
						if (step_done) begin
							state <= SEQ_SYS_REQ;
						end
					end
					SEQ_SYS_WAIT: begin
						// poll until the target reports NVM programming mode
						if (step_done) begin
							if (chk_byte[SYS_NVMPROG_BIT]) begin
								state <= SEQ_PTR_REQ;
							end else begin
								delay_cnt <= DELAY_W'(`UPDI_RESET_DELAY_CLKS - 1);
								state <= SEQ_SYS_DELAY;
							end
						end
					end
					SEQ_SYS_DELAY: begin
						if (delay_cnt == '0) begin
							state <= SEQ_SYS_REQ;
						end
					end
					SEQ_PTR_WAIT: begin
						if (step_done) begin
							state <= SEQ_RPT_REQ;
						end
					end
					SEQ_RPT_WAIT: begin
						if (step_done) begin
							state <= SEQ_LD_REQ;
						end
					end
					SEQ_LD_WAIT: begin
						// first byte read ends up most significant
						if (resp_valid) begin
							device_id <= {device_id[15:0], resp_byte};
						end
						if (step_done) begin
							done <= 1'b1;
							state <= SEQ_IDLE;
						end
					end
					default: state <= SEQ_IDLE;
				endcase
			end
		end
	end

	// the frame builder takes a command only while it is ready
	assert property (@(posedge clk) disable iff (rst) cmd_valid |-> builder_ready);

endmodule

// File: hw/updi_frame_builder.sv
// assumes the TX FIFO accepts a write in any cycle where tx_full is low; no ACK is checked
`timescale 1ns/1ps
`include "updi_macros.svh"

module updi_frame_builder (
	input  logic clk,
	input  logic rst,
	input  logic cmd_valid,
	input  updi_proto_pkg::updi_opcode_u cmd_opcode,
	input  logic [63:0] cmd_operands,
	input  logic [3:0] cmd_operand_count,
	output logic builder_ready,
	output logic frame_sent,
	output logic [7:0] tx_data,
	output logic tx_wr_en,
	input  logic tx_full
);
	import updi_proto_pkg::*;

	logic active;
	logic [3:0] idx, last_idx;
	updi_opcode_u opcode_q;
	logic [63:0] operands_q;
	logic [3:0] count_q;

	assign builder_ready = !active;
	assign tx_wr_en = active && !tx_full;

	// byte 0 is SYNCH, byte 1 the opcode, the rest are operands
	assign last_idx = count_q + 4'd1;

	always_comb begin
		case (idx)
			4'd0: tx_data = `UPDI_SYNCH;
			4'd1: tx_data = opcode_q;
			default: tx_data = operands_q[7:0];
		endcase
	end

	always_ff @(posedge clk) begin
		frame_sent <= 1'b0;
		if (rst) begin
			active <= 1'b0;
			idx <= 4'd0;
		end else if (!active) begin
			if (cmd_valid) begin
				active <= 1'b1;
				idx <= 4'd0;
			end
		end else if (tx_wr_en) begin
			idx <= idx + 4'd1;
			if (idx == last_idx) begin
				active <= 1'b0;
				frame_sent <= 1'b1;
			end
		end
	end

	// operands shift out lowest byte first
	always_ff @(posedge clk) begin
		if (cmd_valid && !active) begin
			opcode_q <= cmd_opcode;
			operands_q <= cmd_operands;
			count_q <= cmd_operand_count;
		end else if (tx_wr_en && idx >= 4'd2) begin
			operands_q <= operands_q >> 8;
		end
	end

	// a stalled byte stays on tx_data until the FIFO takes it
	assert property (@(posedge clk) disable iff (rst) active && tx_full |=> $stable(tx_data));
	assert property (@(posedge clk) disable iff (rst)
		cmd_valid |-> cmd_operand_count <= UPDI_MAX_OPERANDS);

endmodule

// File: hw/updi_rx_collector.sv
// RX FIFO must present read data the cycle after rx_rd_en; a timeout drops the rest of the reply
`timescale 1ns/1ps
`include "updi_macros.svh"

module updi_rx_collector (
	input  logic clk,
	input  logic rst,
	input  logic rx_expect,
	input  logic [1:0] rx_count,
	input  logic [7:0] rx_data,
	output logic rx_rd_en,
	input  logic rx_empty,
	output logic resp_valid,
	output logic [7:0] resp_byte,
	output logic resp_done,
	output logic rx_timeout
);
	localparam int IDLE_W = $clog2(`UPDI_RX_TIMEOUT_CLKS + 1);

	// armed while bytes are still owed
	logic [1:0] rd_left;
	logic [IDLE_W-1:0] idle_cnt;

	assign rx_rd_en = (rd_left != 2'd0) && !rx_empty;
	assign resp_byte = rx_data;

	always_ff @(posedge clk) begin
		resp_valid <= 1'b0;
		resp_done <= 1'b0;
		rx_timeout <= 1'b0;
		if (rst) begin
			rd_left <= 2'd0;
			idle_cnt <= '0;
		end else if (rx_expect) begin
			rd_left <= rx_count;
			idle_cnt <= '0;
		end else if (rx_rd_en) begin
			resp_valid <= 1'b1;
			resp_done <= (rd_left == 2'd1);
			rd_left <= rd_left - 2'd1;
			idle_cnt <= '0;
		end else if (rd_left != 2'd0) begin
			// the idle window restarts with every byte
			if (idle_cnt == IDLE_W'(`UPDI_RX_TIMEOUT_CLKS - 1)) begin
				rx_timeout <= 1'b1;
				rd_left <= 2'd0;
			end else begin
				idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

	// a new reply is awaited only once the previous one has ended
	assert property (@(posedge clk) disable iff (rst) rx_expect |-> rd_left == 2'd0);

endmodule

// File: hw/updi_programmer_top.sv
// the UART PHY and double-break generator sit outside; only their FIFO and pulse ports are here
`timescale 1ns/1ps

module updi_programmer_top (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic busy,
	output logic done,
	output logic error,
	output logic [23:0] device_id,
	output logic double_break_start,
	input  logic double_break_done,
	output logic [7:0] tx_data,
	output logic tx_wr_en,
	input  logic tx_full,
	input  logic [7:0] rx_data,
	output logic rx_rd_en,
	input  logic rx_empty
);
	import updi_proto_pkg::*;

	logic cmd_valid, builder_ready, frame_sent;
	updi_opcode_u cmd_opcode;
	logic [63:0] cmd_operands;
	logic [3:0] cmd_operand_count;
	logic rx_expect, resp_valid, resp_done, rx_timeout;
	logic [1:0] rx_count;
	logic [7:0] resp_byte;

	updi_sequencer sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.error(error),
		.device_id(device_id),
		.double_break_start(double_break_start),
		.double_break_done(double_break_done),
		.cmd_valid(cmd_valid),
		.cmd_opcode(cmd_opcode),
		.cmd_operands(cmd_operands),
		.cmd_operand_count(cmd_operand_count),
		.builder_ready(builder_ready),
		.frame_sent(frame_sent),
		.rx_expect(rx_expect),
		.rx_count(rx_count),
		.resp_valid(resp_valid),
		.resp_byte(resp_byte),
		.resp_done(resp_done),
		.rx_timeout(rx_timeout)
	);

	updi_frame_builder frame_builder (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_opcode(cmd_opcode),
		.cmd_operands(cmd_operands),
		.cmd_operand_count(cmd_operand_count),
		.builder_ready(builder_ready),
		.frame_sent(frame_sent),
		.tx_data(tx_data),
		.tx_wr_en(tx_wr_en),
		.tx_full(tx_full)
	);

	updi_rx_collector rx_collector (
		.clk(clk),
		.rst(rst),
		.rx_expect(rx_expect),
		.rx_count(rx_count),
		.rx_data(rx_data),
		.rx_rd_en(rx_rd_en),
		.rx_empty(rx_empty),
		.resp_valid(resp_valid),
		.resp_byte(resp_byte),
		.resp_done(resp_done),
		.rx_timeout(rx_timeout)
	);

endmodule

// File: verification/updi_target_model.sv
// answers LDCS with one byte and LD with REPEAT+1 bytes in stim order; holds 16 replies, logs 64 TX bytes
`timescale 1ns/1ps

module updi_target_model (
	input  logic clk,
	input  logic rst,
	input  logic double_break_start,
	output logic double_break_done,
	input  logic [7:0] tx_data,
	input  logic tx_wr_en,
	input  logic tx_full,
	output logic [7:0] rx_data,
	input  logic rx_rd_en,
	output logic rx_empty,
	input  logic [7:0] resp_list [16],
	input  logic [7:0] resp_total,
	output logic [7:0] tx_log [64],
	output logic [7:0] tx_count
);
	logic [2:0] db_cnt = 3'd0;
	logic db_pulse = 1'b0;
	logic [7:0] rx_byte = 8'h00;
	// bytes released to the RX side and bytes already read
	logic [7:0] rel = 8'd0;
	logic [7:0] rd_ptr = 8'd0;
	logic [3:0] skip = 4'd0;
	logic expect_opc = 1'b0;
	logic rpt_operand = 1'b0;
	logic [7:0] rpt_len = 8'd0;
	logic [7:0] release_n;
	logic accepted;

	assign double_break_done = db_pulse;
	assign rx_data = rx_byte;
	assign rx_empty = (rd_ptr == rel);
	assign accepted = tx_wr_en && !tx_full;

	// reply length owed for an opcode byte
	always_comb begin
		case (tx_data[7:5])
			3'd4: release_n = 8'd1;
			3'd1: release_n = rpt_len + 8'd1;
			default: release_n = 8'd0;
		endcase
	end

	// operand bytes that follow an opcode on the wire
	function automatic logic [3:0] operand_len(input logic [7:0] opc);
		case (opc[7:5])
			3'd3: return {2'b00, opc[1:0]} + 4'd1;
			3'd5, 3'd6: return 4'd1;
			3'd7: return 4'd8;
			default: return 4'd0;
		endcase
	endfunction

	always @(posedge clk) begin
		db_pulse <= 1'b0;
		if (rst) begin
			db_cnt <= 3'd0;
			rel <= 8'd0;
			rd_ptr <= 8'd0;
			skip <= 4'd0;
			expect_opc <= 1'b0;
			rpt_operand <= 1'b0;
			rpt_len <= 8'd0;
			tx_count <= 8'd0;
		end else begin
			// double break takes a few cycles on the line
			if (double_break_start) begin
				db_cnt <= 3'd4;
			end else if (db_cnt != 3'd0) begin
				db_cnt <= db_cnt - 3'd1;
				db_pulse <= (db_cnt == 3'd1);
			end
			if (rx_rd_en) begin
				rx_byte <= resp_list[rd_ptr[3:0]];
				rd_ptr <= rd_ptr + 8'd1;
			end
			if (accepted) begin
				if (tx_count < 8'd64) begin
					tx_log[tx_count[5:0]] <= tx_data;
				end
				tx_count <= tx_count + 8'd1;
				if (skip != 4'd0) begin
					skip <= skip - 4'd1;
					if (rpt_operand) begin
						rpt_len <= tx_data;
					end
					rpt_operand <= 1'b0;
				end else if (expect_opc) begin
					expect_opc <= 1'b0;
					skip <= operand_len(tx_data);
					rpt_operand <= (tx_data[7:5] == 3'd5);
					// a short stim list leaves the reply missing
					rel <= (rel + release_n > resp_total) ? resp_total : rel + release_n;
					if (tx_data[7:5] == 3'd1) begin
						rpt_len <= 8'd0;
					end
				end else if (tx_data == 8'h55) begin
					expect_opc <= 1'b1;
				end
			end
		end
	end

endmodule

// File: verification/tb_updi_programmer.sv
// reads verification/updi_stim.txt relative to the run directory; stops at the first mismatch
`timescale 1ns/1ps

module tb_updi_programmer;
	logic clk = 1'b0;
	logic rst;
	logic start;
	logic tx_full = 1'b0;
	logic stall_en = 1'b0;
	logic busy, done, error;
	logic [23:0] device_id;
	logic double_break_start, double_break_done;
	logic [7:0] tx_data, rx_data;
	logic tx_wr_en, rx_rd_en, rx_empty;

	// reply bytes and TX log shared with the target model
	logic [7:0] resp_list [16];
	logic [7:0] resp_total;
	logic [7:0] tx_log [64];
	logic [7:0] tx_count;
	logic [7:0] stim [512];

	always #10 clk = ~clk;

	// back-pressure in about one cycle of four when enabled
	always @(posedge clk) begin
		tx_full <= stall_en && (($urandom % 4) == 0);
	end

	updi_programmer_top uut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.error(error),
		.device_id(device_id),
		.double_break_start(double_break_start),
		.double_break_done(double_break_done),
		.tx_data(tx_data),
		.tx_wr_en(tx_wr_en),
		.tx_full(tx_full),
		.rx_data(rx_data),
		.rx_rd_en(rx_rd_en),
		.rx_empty(rx_empty)
	);

	updi_target_model model (
		.clk(clk),
		.rst(rst),
		.double_break_start(double_break_start),
		.double_break_done(double_break_done),
		.tx_data(tx_data),
		.tx_wr_en(tx_wr_en),
		.tx_full(tx_full),
		.rx_data(rx_data),
		.rx_rd_en(rx_rd_en),
		.rx_empty(rx_empty),
		.resp_list(resp_list),
		.resp_total(resp_total),
		.tx_log(tx_log),
		.tx_count(tx_count)
	);

	task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
		if (got !== expected) begin
			$display("MISMATCH at %0d ns: %s, got %0h, expected %0h", $time, what, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic apply_reset();
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic wait_for_end(input int tid, output logic got_done, output logic got_error);
		int cycles;
		cycles = 0;
		got_done = 1'b0;
		got_error = 1'b0;
		while (!got_done && !got_error) begin
			@(negedge clk);
			got_done = done;
			got_error = error;
			if (!got_done && !got_error) begin
				check(32'(busy), 32'd1, $sformatf("test %0d busy while running", tid));
			end
			cycles++;
			if (cycles > 20000) begin
				abort_run($sformatf("test %0d never pulsed done or error", tid));
			end
		end
	endtask

	initial begin
		int n_tests;
		int sp;
		int tid;
		int n_resp;
		int n_tx;
		logic exp_error;
		logic [23:0] exp_id;
		logic got_done;
		logic got_error;

		rst = 1'b1;
		start = 1'b0;
		resp_total = 8'd0;
		for (int i = 0; i < 16; i++) begin
			resp_list[i] = 8'h00;
		end
		void'($urandom(9277));
		$readmemh("verification/updi_stim.txt", stim);
		apply_reset();
		@(negedge clk);
		check(32'({busy, done, error, tx_wr_en, rx_rd_en, double_break_start}), 32'd0,
			"control outputs after reset");
		check(32'(device_id), 32'd0, "device_id after reset");

		n_tests = int'(stim[0]);
		if (n_tests == 0) begin
			abort_run("the stim file is missing or holds no tests");
		end
		sp = 1;
		for (int t = 0; t < n_tests; t++) begin
			tid = int'(stim[sp]);
			exp_error = stim[sp + 2][0];
			n_resp = int'(stim[sp + 3]);
			@(posedge clk);
			stall_en <= stim[sp + 1][0];
			resp_total <= 8'(n_resp);
			sp += 4;
			for (int i = 0; i < n_resp; i++) begin
				resp_list[i] <= stim[sp + i];
			end
			sp += n_resp;
			exp_id = {stim[sp], stim[sp + 1], stim[sp + 2]};
			n_tx = int'(stim[sp + 3]);
			sp += 4;

			apply_reset();
			@(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			wait_for_end(tid, got_done, got_error);
			check(32'(got_error), 32'(exp_error), $sformatf("test %0d error pulse", tid));
			check(32'(got_done), 32'(!exp_error), $sformatf("test %0d done pulse", tid));
			check(32'(busy), 32'd0, $sformatf("test %0d busy at the end", tid));

			// the line must stay silent once the run is over
			repeat (40) begin
				@(negedge clk);
				check(32'(tx_wr_en), 32'd0, $sformatf("test %0d TX write after the end", tid));
				check(32'({done, error}), 32'd0,
					$sformatf("test %0d done or error after the end", tid));
			end
			check(32'(tx_count), 32'(n_tx), $sformatf("test %0d TX byte count", tid));
			for (int i = 0; i < n_tx; i++) begin
				check(32'(tx_log[i]), 32'(stim[sp + i]), $sformatf("test %0d TX byte %0d", tid, i));
			end
			check(32'(device_id), 32'(exp_id), $sformatf("test %0d device_id", tid));
			sp += n_tx;
			$display("test %0d finished", tid);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: verification/updi_stim.txt
// test_id stall(1 = random tx_full) outcome(0 done, 1 error) n_resp resp_bytes
// then device_id[23:16] [15:8] [7:0], n_tx, expected TX bytes; all values hex
06
// nominal run
01 00 00 06 30 10 08 1E 93 0B
1E 93 0B 1F
55 80 55 E0 20 67 6F 72 50 4D 56 4E 55 87
55 C8 59 55 C8 00 55 8B 55 69 00 11 55 A0 02 55 24
// SYS_STATUS polled three times
02 00 00 08 30 10 00 00 08 1E 94 22
1E 94 22 23
55 80 55 E0 20 67 6F 72 50 4D 56 4E 55 87
55 C8 59 55 C8 00 55 8B 55 8B 55 8B
55 69 00 11 55 A0 02 55 24
// KEY_STATUS without NVMPROG
03 00 01 02 30 00
00 00 00 0E
55 80 55 E0 20 67 6F 72 50 4D 56 4E 55 87
// STATUSA reads zero
04 00 01 01 00
00 00 00 02
55 80
// SYS_STATUS reply withheld
05 00 01 02 30 10
00 00 00 16
55 80 55 E0 20 67 6F 72 50 4D 56 4E 55 87
55 C8 59 55 C8 00 55 8B
// nominal run under TX back-pressure
06 01 00 06 30 10 08 1E 93 0B
1E 93 0B 1F
55 80 55 E0 20 67 6F 72 50 4D 56 4E 55 87
55 C8 59 55 C8 00 55 8B 55 69 00 11 55 A0 02 55 24

// File: sources.f
+incdir+hw
hw/updi_proto_pkg.sv
hw/updi_asi_pkg.sv
hw/updi_sequencer.sv
hw/updi_frame_builder.sv
hw/updi_rx_collector.sv
hw/updi_programmer_top.sv
verification/updi_target_model.sv
verification/tb_updi_programmer.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of tb_updi_programmer; the log decides the verdict
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_updi_programmer \
	-f sources.f -o sim_updi &&
./obj_dir/sim_updi > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log 2>/dev/null && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log 2>/dev/null || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
